/* Makefile */
# Verilator flow for the four-port packet merger

TB_TOP = tb_packet_merge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only +incdir+rtl \
		rtl/stream_pkg.sv rtl/packet_arbiter.sv rtl/output_skid_buffer.sv \
		rtl/stream_arb_mux.sv rtl/packet_merge_top.sv \
		--top-module packet_merge_top

sim:
	verilator --binary --timing -f packet_merge_top.f \
		--top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) > sim.log
	cat sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* packet_merge_top.f */
+incdir+rtl
rtl/stream_pkg.sv
rtl/packet_arbiter.sv
rtl/output_skid_buffer.sv
rtl/stream_arb_mux.sv
rtl/packet_merge_top.sv
verification/merge_checker.sv
verification/tb_packet_merge.sv

/* rtl/output_skid_buffer.sv */
// **************************************************
// two-entry output skid buffer
// **************************************************

`timescale 1ns/1ps

module output_skid_buffer (
    input  logic                  clk,
    input  logic                  rst,

    // beat from the source mux
    input  stream_pkg::beat_t     int_data,
    input  stream_pkg::user_t     int_user,
    input  stream_pkg::port_idx_t int_port,
    input  logic                  int_last,
    input  logic                  int_valid,
    output logic                  int_ready,

    // merged output stream
    output stream_pkg::beat_t     m_data,
    output stream_pkg::user_t     m_user,
    output stream_pkg::port_idx_t m_port,
    output logic                  m_last,
    output logic                  m_valid,
    input  logic                  m_ready
);

    import stream_pkg::*;

    // temp entry catches the beat accepted while the output stalls
    beat_t     temp_data;
    user_t     temp_user;
    port_idx_t temp_port;
    logic      temp_last;
    logic      temp_valid;

    logic      m_valid_next;
    logic      temp_valid_next;
    logic      int_ready_early;

    logic      store_int_to_output;
    logic      store_int_to_temp;
    logic      store_temp_to_output;

    // ready next cycle unless the temp entry could fill up
    assign int_ready_early = m_ready || (!temp_valid && (!m_valid || !int_valid));

    always_comb begin
        m_valid_next         = m_valid;
        temp_valid_next      = temp_valid;
        store_int_to_output  = 1'b0;
        store_int_to_temp    = 1'b0;
        store_temp_to_output = 1'b0;

        if (int_ready) begin
            if (m_ready || !m_valid) begin
                // output free or draining
                m_valid_next        = int_valid;
                store_int_to_output = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next   = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            // input closed, drain temp into output
            m_valid_next         = temp_valid;
            temp_valid_next      = 1'b0;
            store_temp_to_output = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            int_ready  <= 1'b0;
        end else begin
            m_valid    <= m_valid_next;
            temp_valid <= temp_valid_next;
            int_ready  <= int_ready_early;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (store_int_to_output) begin
            m_data <= int_data;
            m_user <= int_user;
            m_port <= int_port;
            m_last <= int_last;
        end else if (store_temp_to_output) begin
            m_data <= temp_data;
            m_user <= temp_user;
            m_port <= temp_port;
            m_last <= temp_last;
        end

        if (store_int_to_temp) begin
            temp_data <= int_data;
            temp_user <= int_user;
            temp_port <= int_port;
            temp_last <= int_last;
        end
    end

endmodule

/* rtl/packet_arbiter.sv */
// **************************************************
// round-robin packet arbiter
// **************************************************

`timescale 1ns/1ps

`include "stream_macros.svh"

module packet_arbiter (
    input  logic                   clk,
    input  logic                   rst,

    // one request and one release bit per port
    input  stream_pkg::port_mask_t request,
    input  stream_pkg::port_mask_t acknowledge,

    // current owner of the output
    output stream_pkg::port_mask_t grant,
    output logic                   grant_valid,
    output stream_pkg::port_idx_t  grant_index
);

    import stream_pkg::*;

    port_idx_t next_index;
    logic      next_found;
    logic      release_grant;

    // owner finished its packet this cycle
    assign release_grant = |(grant & acknowledge);

    // search starts one above the last grant and wraps around
    always_comb begin
        int cand;

        cand       = 0;
        next_found = 1'b0;
        next_index = grant_index;
        for (int i = 1; i <= `STREAM_PORTS; i++) begin
            cand = (int'(grant_index) + i) % `STREAM_PORTS;
            if (!next_found && request[cand]) begin
                next_found = 1'b1;
                next_index = port_idx_t'(cand);
            end
        end
    end

    // grant_index doubles as the round-robin pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            // pointer at the top port so port 0 wins first
            grant_index <= port_idx_t'(`STREAM_PORTS - 1);
        end else if (!grant_valid || release_grant) begin
            if (next_found) begin
                grant       <= port_mask_t'(1) << next_index;
                grant_valid <= 1'b1;
                grant_index <= next_index;
            end else begin
                // idle, pointer keeps the last winner
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end
        // otherwise grant held until the packet ends
    end

endmodule

/* rtl/packet_merge_top.sv */
// **************************************************
// four-port packet merger
// **************************************************

`timescale 1ns/1ps

`include "stream_macros.svh"

module packet_merge_top (
    input  logic                                        clk,
    input  logic                                        rst,

    // flat source buses, port 0 in the low bits
    input  logic [`STREAM_PORTS*`STREAM_DATA_WIDTH-1:0] s_data,
    input  logic [`STREAM_PORTS*`STREAM_USER_WIDTH-1:0] s_user,
    input  logic [`STREAM_PORTS-1:0]                    s_valid,
    input  logic [`STREAM_PORTS-1:0]                    s_last,
    output logic [`STREAM_PORTS-1:0]                    s_ready,

    // merged output with source tag
    output logic [`STREAM_DATA_WIDTH-1:0]               m_data,
    output logic [`STREAM_USER_WIDTH-1:0]               m_user,
    output logic [$clog2(`STREAM_PORTS)-1:0]            m_port,
    output logic                                        m_last,
    output logic                                        m_valid,
    input  logic                                        m_ready
);

    stream_arb_mux u_stream_arb_mux (
        .clk     (clk),
        .rst     (rst),
        .s_data  (s_data),
        .s_user  (s_user),
        .s_valid (s_valid),
        .s_last  (s_last),
        .s_ready (s_ready),
        .m_data  (m_data),
        .m_user  (m_user),
        .m_port  (m_port),
        .m_last  (m_last),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

/* rtl/stream_arb_mux.sv */
// **************************************************
// arbitrated stream multiplexer
// **************************************************

`timescale 1ns/1ps

`include "stream_macros.svh"

module stream_arb_mux (
    input  logic                                     clk,
    input  logic                                     rst,

    // source streams
    input  stream_pkg::beat_t [`STREAM_PORTS-1:0]    s_data,
    input  stream_pkg::user_t [`STREAM_PORTS-1:0]    s_user,
    input  stream_pkg::port_mask_t                   s_valid,
    input  stream_pkg::port_mask_t                   s_last,
    output stream_pkg::port_mask_t                   s_ready,

    // merged stream
    output stream_pkg::beat_t                        m_data,
    output stream_pkg::user_t                        m_user,
    output stream_pkg::port_idx_t                    m_port,
    output logic                                     m_last,
    output logic                                     m_valid,
    input  logic                                     m_ready
);

    import stream_pkg::*;

    port_mask_t request;
    port_mask_t acknowledge;
    port_mask_t grant;
    logic       grant_valid;
    port_idx_t  grant_index;

    beat_t      int_data;
    user_t      int_user;
    logic       int_last;
    logic       int_valid;
    logic       int_ready;

    // owner is masked out so it cannot re-request mid packet
    assign request     = s_valid & ~grant;
    // release on the accepted last beat
    assign acknowledge = grant & s_valid & s_ready & s_last;

    // only the owner sees ready
    assign s_ready = port_mask_t'(int_ready && grant_valid) << grant_index;

    // steer the owner's beat to the output stage
    assign int_data  = s_data[grant_index];
    assign int_user  = s_user[grant_index];
    assign int_last  = s_last[grant_index];
    assign int_valid = s_valid[grant_index] && int_ready && grant_valid;

    packet_arbiter u_packet_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    output_skid_buffer u_output_skid_buffer (
        .clk       (clk),
        .rst       (rst),
        .int_data  (int_data),
        .int_user  (int_user),
        .int_port  (grant_index),
        .int_last  (int_last),
        .int_valid (int_valid),
        .int_ready (int_ready),
        .m_data    (m_data),
        .m_user    (m_user),
        .m_port    (m_port),
        .m_last    (m_last),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

endmodule

/* rtl/stream_macros.svh */
// **************************************************
// packet merge widths and port count
// **************************************************

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// number of merged input streams
`define STREAM_PORTS 4

// bits per data beat
`define STREAM_DATA_WIDTH 8

// sideband user bits carried with every beat
`define STREAM_USER_WIDTH 1

`endif

/* rtl/stream_pkg.sv */
// **************************************************
// packet merge shared types
// **************************************************

`include "stream_macros.svh"

package stream_pkg;

    // one beat of payload
    typedef logic [`STREAM_DATA_WIDTH-1:0] beat_t;

    // user sideband
    typedef logic [`STREAM_USER_WIDTH-1:0] user_t;

    // one bit per input port
    typedef logic [`STREAM_PORTS-1:0] port_mask_t;

    // encoded source port number
    typedef logic [$clog2(`STREAM_PORTS)-1:0] port_idx_t;

endpackage

/* verification/merge_checker.sv */
// **************************************************
// packet merge output checker
// **************************************************

`timescale 1ns/1ps

`include "stream_macros.svh"

module merge_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`STREAM_PORTS-1:0]           s_ready,
    input  logic [`STREAM_DATA_WIDTH-1:0]      m_data,
    input  logic [`STREAM_USER_WIDTH-1:0]      m_user,
    input  logic [$clog2(`STREAM_PORTS)-1:0]   m_port,
    input  logic                               m_last,
    input  logic                               m_valid,
    input  logic                               m_ready
);

    // expected beat word is {user, last, data}
    logic [9:0] exp_q [`STREAM_PORTS][$];

    int         pending_beats = 0;
    int         test_num = 0;
    int         test_errors = 0;
    int         test_beats = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         total_errors = 0;
    bit         rr_on = 0;

    logic       rst_d = 1'b0;
    logic       stalled = 1'b0;
    logic       in_pkt = 1'b0;
    logic       have_prev = 1'b0;
    logic [1:0] cur_port = '0;
    logic [1:0] prev_port = '0;
    logic [11:0] held;

    task automatic start_test(input int num, input bit rr);
        test_num    = num;
        rr_on       = rr;
        test_errors = 0;
        test_beats  = 0;
        have_prev   = 1'b0;
    endtask

    task automatic push_expected(input int port, input logic [9:0] word);
        exp_q[port].push_back(word);
        pending_beats++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d passed, %0d beats", test_num, test_beats);
        end else begin
            fail_count++;
            $display("test %0d failed with %0d errors", test_num, test_errors);
        end
    endtask

    task automatic flag(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("error test %0d %s expected %h actual %h", test_num, what, exp, act);
        test_errors++;
        total_errors++;
    endtask

    always @(posedge clk) begin
        logic [9:0] w;
        logic [1:0] next_port;

        // outputs quiet through reset and the cycle after it
        if (rst_d) begin
            if (m_valid !== 1'b0)
                flag("m_valid", 32'h0, 32'(m_valid));
            if (s_ready !== '0)
                flag("s_ready", 32'h0, 32'(s_ready));
        end
        rst_d <= rst;

        if (!rst && stalled) begin
            if (m_valid !== 1'b1)
                flag("m_valid", 32'h1, 32'(m_valid));
            else if ({m_user, m_last, m_port, m_data} !== held)
                flag("stalled payload", 32'(held), 32'({m_user, m_last, m_port, m_data}));
        end
        stalled <= !rst && m_valid && !m_ready;
        held    <= {m_user, m_last, m_port, m_data};

        if (!rst && m_valid && m_ready) begin
            test_beats++;
            if (in_pkt && m_port != cur_port)
                flag("m_port", 32'(cur_port), 32'(m_port));
            if (!in_pkt) begin
                next_port = prev_port + 2'd1;
                if (rr_on && have_prev && m_port != next_port)
                    flag("m_port", 32'(next_port), 32'(m_port));
                have_prev = 1'b1;
                prev_port = m_port;
            end
            cur_port = m_port;
            in_pkt   = !m_last;
            if (exp_q[m_port].size() == 0) begin
                $display("test %0d: unexpected beat from port %0d with nothing queued",
                         test_num, m_port);
                test_errors++;
                total_errors++;
            end else begin
                w = exp_q[m_port].pop_front();
                pending_beats--;
                if (m_data !== w[7:0])
                    flag("m_data", 32'(w[7:0]), 32'(m_data));
                if (m_last !== w[8])
                    flag("m_last", 32'(w[8]), 32'(m_last));
                if (m_user !== w[9])
                    flag("m_user", 32'(w[9]), 32'(m_user));
            end
        end
    end

endmodule

/* verification/merge_tests.txt */
# T <test> <stall percent> <all ports start together>
# B <test> <port> <data hex> <last> <user>
T 1 0 1
B 1 0 10 0 0
B 1 0 11 1 1
B 1 0 12 0 1
B 1 0 13 1 0
B 1 1 20 0 1
B 1 1 21 1 0
B 1 1 22 0 0
B 1 1 23 1 1
B 1 2 30 0 0
B 1 2 31 1 0
B 1 2 32 0 1
B 1 2 33 1 1
B 1 3 40 0 1
B 1 3 41 1 1
B 1 3 42 0 0
B 1 3 43 1 0
T 2 30 1
B 2 0 a0 1 1
B 2 0 a1 0 0
B 2 0 a2 0 1
B 2 0 a3 1 0
B 2 1 b0 1 0
B 2 1 b1 0 1
B 2 1 b2 0 1
B 2 1 b3 1 1
B 2 2 c0 1 1
B 2 2 c1 0 0
B 2 2 c2 0 0
B 2 2 c3 1 1
B 2 3 d0 1 0
B 2 3 d1 0 0
B 2 3 d2 0 1
B 2 3 d3 1 0
T 3 0 0
B 3 2 55 1 0
B 3 2 aa 1 1
B 3 2 5a 1 1
B 3 2 a5 1 0
B 3 2 ff 1 1
T 4 50 0
B 4 0 e0 0 0
B 4 0 e1 0 1
B 4 0 e2 0 1
B 4 0 e3 1 0
B 4 1 71 0 1
B 4 1 72 0 0
B 4 1 73 1 1
B 4 1 74 1 0
B 4 3 91 0 0
B 4 3 92 1 1
B 4 3 93 0 1
B 4 3 94 1 1

/* verification/tb_packet_merge.sv */
// **************************************************
// packet merge testbench
// **************************************************

`timescale 1ns/1ps

`include "stream_macros.svh"

module tb_packet_merge;

    localparam int    CLK_PERIOD = 10;
    localparam string TEST_FILE  = "verification/merge_tests.txt";

    logic        clk;
    logic        rst;
    logic [31:0] s_data;
    logic [3:0]  s_user;
    logic [3:0]  s_valid;
    logic [3:0]  s_last;
    logic [3:0]  s_ready;
    logic [7:0]  m_data;
    logic [0:0]  m_user;
    logic [1:0]  m_port;
    logic        m_last;
    logic        m_valid;
    logic        m_ready;

    // file contents
    int          test_stall [int];
    int          test_together [int];
    int          beat_test [$];
    int          beat_port [$];
    logic [9:0]  beat_word [$];
    int          max_test;

    // per-port beats still to send in the running test
    logic [9:0]  port_q [4][$];
    logic [3:0]  took;
    bit          running;
    bit          together;
    int          stall_pct;
    int          test_cycle;

    packet_merge_top u_packet_merge_top (
        .clk(clk), .rst(rst),
        .s_data(s_data), .s_user(s_user), .s_valid(s_valid),
        .s_last(s_last), .s_ready(s_ready),
        .m_data(m_data), .m_user(m_user), .m_port(m_port),
        .m_last(m_last), .m_valid(m_valid), .m_ready(m_ready)
    );

    merge_checker u_merge_checker (
        .clk(clk), .rst(rst), .s_ready(s_ready),
        .m_data(m_data), .m_user(m_user), .m_port(m_port),
        .m_last(m_last), .m_valid(m_valid), .m_ready(m_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_tests(output bit loaded);
        int    fd;
        int    code;
        int    t;
        int    a;
        int    b;
        int    d;
        int    l;
        int    u;
        string line;

        max_test = 0;
        loaded   = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            loaded = 1'b1;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code == 0)
                    break;
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                if (line.getc(0) == "T") begin
                    code = $sscanf(line, "T %d %d %d", t, a, b);
                    test_stall[t]    = a;
                    test_together[t] = b;
                    if (t > max_test)
                        max_test = t;
                end else if (line.getc(0) == "B") begin
                    code = $sscanf(line, "B %d %d %h %d %d", t, a, d, l, u);
                    beat_test.push_back(t);
                    beat_port.push_back(a);
                    beat_word.push_back({u[0], l[0], d[7:0]});
                end
            end
            $fclose(fd);
        end
    endtask

    // sources and sink driven on the falling edge
    always @(posedge clk) took <= s_valid & s_ready;

    always @(negedge clk) begin
        logic [9:0] w;

        test_cycle++;
        if (!rst)
            m_ready = (stall_pct == 0) ? 1'b1 : (($urandom % 100) >= stall_pct);
        for (int p = 0; p < 4; p++) begin
            if (took[p] && port_q[p].size() > 0)
                void'(port_q[p].pop_front());
            // staggered ports start 9 cycles apart
            if (running && port_q[p].size() > 0 && (together || test_cycle >= p * 9)) begin
                w = port_q[p][0];
                s_data[p*8 +: 8] = w[7:0];
                s_last[p]        = w[8];
                s_user[p]        = w[9];
                s_valid[p]       = 1'b1;
            end else begin
                s_valid[p] = 1'b0;
            end
        end
    end

    // watchdog sized from the beat count in the file
    initial begin
        @(negedge rst);
        repeat (40 * beat_word.size() + 200) @(posedge clk);
        $display("timeout: outputs still missing after the time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit loaded;

        rst        = 1'b1;
        s_data     = '0;
        s_user     = '0;
        s_valid    = '0;
        s_last     = '0;
        m_ready    = 1'b0;
        took       = '0;
        running    = 1'b0;
        together   = 1'b1;
        stall_pct  = 0;
        test_cycle = 0;
        void'($urandom(32'h276b));
        load_tests(loaded);

        if (!loaded) begin
            $display("could not open %s", TEST_FILE);
            $display("TEST FAILED");
        end else begin
            repeat (5) @(negedge clk);
            rst = 1'b0;
            repeat (2) @(negedge clk);

            for (int t = 1; t <= max_test; t++) begin
                if (!test_stall.exists(t))
                    continue;
                u_merge_checker.start_test(t, test_together[t] != 0);
                for (int i = 0; i < beat_word.size(); i++) begin
                    if (beat_test[i] == t) begin
                        port_q[beat_port[i]].push_back(beat_word[i]);
                        u_merge_checker.push_expected(beat_port[i], beat_word[i]);
                    end
                end
                @(posedge clk);
                stall_pct  = test_stall[t];
                together   = test_together[t] != 0;
                test_cycle = 0;
                running    = 1'b1;
                while (u_merge_checker.pending_beats != 0)
                    @(posedge clk);
                running = 1'b0;
                repeat (4) @(posedge clk);
                u_merge_checker.finish_test();
            end

            $display("tests passed %0d failed %0d", u_merge_checker.pass_count,
                     u_merge_checker.fail_count);
            if (u_merge_checker.fail_count == 0 && u_merge_checker.total_errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule
